//--- dv/execPipeTb.sv
`include "exec_settings.svh"
`default_nettype none

module execPipeTb import execPkg::*; ();
    logic   clk;
    logic   rstN;
    issueT  issue;
    logic   issueValid;
    logic   issueReady;
    resultT result;
    logic   resultValid;
    logic   resultReady;

    logic [31:0] lfsrState;
    logic        randomReady;
    int          errCount;
    int          cycle;
    int          acceptCycle;
    int          lastResultCycle;
    resultT      expQ[$];
    resultT      expHead;

    execPipe execPipe_inst (
        .clk         (clk),
        .rstN        (rstN),
        .issue       (issue),
        .issueValid  (issueValid),
        .issueReady  (issueReady),
        .result      (result),
        .resultValid (resultValid),
        .resultReady (resultReady)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // galois form, one step per bit taken
    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) lfsrState = lfsrState ^ 32'h80200003;
        return outBit;
    endfunction

    function automatic xlenT rand64();
        xlenT v;
        v = '0;
        for (int k = 0; k < 64; k++) v = {v[62:0], lfsrBit()};
        return v;
    endfunction

    function automatic instT encode(logic [6:0] f7, logic [2:0] f3, logic [6:0] op);
        return {f7, 5'd2, 5'd1, f3, 5'd3, op};
    endfunction

    function automatic issueT makePkt(instT inst);
        issueT p;
        p.inst = inst;
        p.pc = rand64() & ~64'h3;
        p.rs1 = rand64();
        p.rs2 = rand64();
        p.imm = rand64();
        p.csrVal = rand64();
        return p;
    endfunction

    // expected result, built from the ISA rules
    function automatic resultT model(issueT i);
        resultT      r;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [6:0]  f7;
        xlenT        b;
        xlenT        alu;
        logic [31:0] w;
        logic        taken;
        r = '0;
        alu = '0;
        w = '0;
        taken = 1'b0;
        op = i.inst[6:0];
        f3 = i.inst[14:12];
        f7 = i.inst[31:25];
        r.nextPc = i.pc + 64'd4;
        b = (op == 7'h33 || op == 7'h3b) ? i.rs2 : i.imm;
        case (op)
            7'h33, 7'h13: begin
                r.rdWrite = 1'b1;
                if (op == 7'h33 && f7 == 7'h01) begin
                    alu = i.rs1 * b;
                    r.illegal = (f3 != 3'h0); // div and rem
                end else begin
                    case (f3)
                        3'h0: alu = (op == 7'h33 && f7 == 7'h20) ? i.rs1 - b : i.rs1 + b;
                        3'h1: alu = i.rs1 << b[5:0];
                        3'h2: alu = {63'h0, $signed(i.rs1) < $signed(b)};
                        3'h3: alu = {63'h0, i.rs1 < b};
                        3'h4: alu = i.rs1 ^ b;
                        3'h5: alu = f7[5] ? xlenT'($signed(i.rs1) >>> b[5:0]) : i.rs1 >> b[5:0];
                        3'h6: alu = i.rs1 | b;
                        default: alu = i.rs1 & b;
                    endcase
                end
                r.rdData = alu;
            end
            7'h3b, 7'h1b: begin
                r.rdWrite = 1'b1;
                case (f3)
                    3'h0: begin
                        if (op == 7'h3b && f7 == 7'h01) w = i.rs1[31:0] * b[31:0];
                        else if (op == 7'h3b && f7 == 7'h20) w = i.rs1[31:0] - b[31:0];
                        else w = i.rs1[31:0] + b[31:0];
                    end
                    3'h1: w = i.rs1[31:0] << b[4:0];
                    3'h5: begin
                        if (f7[5]) w = $signed(i.rs1[31:0]) >>> b[4:0];
                        else w = i.rs1[31:0] >> b[4:0];
                    end
                    default: r.illegal = 1'b1;
                endcase
                if (op == 7'h3b && f7 == 7'h01 && f3 != 3'h0) r.illegal = 1'b1;
                r.rdData = {{32{w[31]}}, w};
            end
            7'h37: begin
                r.rdWrite = 1'b1;
                r.rdData = i.imm;
            end
            7'h17: begin
                r.rdWrite = 1'b1;
                r.rdData = i.pc + i.imm;
            end
            7'h6f, 7'h67: begin
                r.rdWrite = 1'b1;
                r.rdData = i.pc + 64'd4;
                r.redirect = 1'b1;
                if (op == 7'h6f) r.nextPc = i.pc + i.imm;
                else r.nextPc = (i.rs1 + i.imm) & ~64'h1;
            end
            7'h63: begin
                case (f3)
                    3'h0: taken = (i.rs1 == i.rs2);
                    3'h1: taken = (i.rs1 != i.rs2);
                    3'h4: taken = ($signed(i.rs1) < $signed(i.rs2));
                    3'h5: taken = ($signed(i.rs1) >= $signed(i.rs2));
                    3'h6: taken = (i.rs1 < i.rs2);
                    3'h7: taken = (i.rs1 >= i.rs2);
                    default: r.illegal = 1'b1;
                endcase
                r.redirect = taken;
                if (taken) r.nextPc = i.pc + i.imm;
            end
            7'h03: begin
                r.rdWrite = 1'b1;
                r.memRead = 1'b1;
                case (f3)
                    3'h0, 3'h4: r.readBytes = 4'd1; // lb, lbu
                    3'h1, 3'h5: r.readBytes = 4'd2; // lh, lhu
                    3'h2, 3'h6: r.readBytes = 4'd4; // lw, lwu
                    3'h3: r.readBytes = 4'd8; // ld
                    default: r.illegal = 1'b1;
                endcase
                r.loadSigned = (f3 <= 3'h3);
                r.memAddr = i.rs1 + i.imm;
            end
            7'h23: begin
                r.memWrite = 1'b1;
                r.memMask = (f3 == 3'h0) ? 8'h01 : (f3 == 3'h1) ? 8'h03 :
                            (f3 == 3'h2) ? 8'h0f : 8'hff;
                r.storeData = i.rs2;
                r.memAddr = i.rs1 + i.imm;
            end
            7'h73: begin
                if (f3 == 3'h1 || f3 == 3'h2) begin
                    r.rdWrite = 1'b1;
                    r.csrWrite = 1'b1;
                    r.rdData = i.csrVal;
                    r.csrData = (f3 == 3'h1) ? i.rs1 : i.rs1 | i.csrVal;
                end else begin
                    r.trap = 1'b1;
                    if (i.imm == 64'h0) r.cause = `CAUSE_ECALL;
                    else if (i.imm == 64'h1) r.cause = `CAUSE_EBREAK;
                    else r.cause = `CAUSE_MRET;
                end
            end
            default: r.illegal = 1'b1;
        endcase
        if (r.illegal) begin
            r.rdWrite = 1'b0;
            r.memRead = 1'b0;
            r.memWrite = 1'b0;
            r.csrWrite = 1'b0;
        end
        return r;
    endfunction

    task automatic checkVal(string name, xlenT got, xlenT exp);
        assert (got === exp) else begin
            errCount++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkResult(resultT got, resultT exp);
        checkVal("rdWrite", got.rdWrite, exp.rdWrite);
        if (exp.rdWrite) checkVal("rdData", got.rdData, exp.rdData);
        checkVal("csrWrite", got.csrWrite, exp.csrWrite);
        if (exp.csrWrite) checkVal("csrData", got.csrData, exp.csrData);
        checkVal("memRead", got.memRead, exp.memRead);
        checkVal("memWrite", got.memWrite, exp.memWrite);
        if (exp.memRead || exp.memWrite) checkVal("memAddr", got.memAddr, exp.memAddr);
        checkVal("memMask", got.memMask, exp.memMask);
        checkVal("readBytes", got.readBytes, exp.readBytes);
        checkVal("loadSigned", got.loadSigned, exp.loadSigned);
        checkVal("storeData", got.storeData, exp.storeData);
        checkVal("nextPc", got.nextPc, exp.nextPc);
        checkVal("redirect", got.redirect, exp.redirect);
        checkVal("illegal", got.illegal, exp.illegal);
        checkVal("trap", got.trap, exp.trap);
        checkVal("cause", got.cause, exp.cause);
    endtask

    // values seen here are the ones that transferred on this edge
    always @(posedge clk) begin
        if (rstN && resultValid && resultReady) begin
            assert (expQ.size() != 0) else begin
                errCount++;
                $display("a result arrived with no instruction outstanding at %0t", $time);
            end
            if (expQ.size() != 0) begin
                expHead = expQ.pop_front();
                checkResult(result, expHead);
            end
            lastResultCycle = cycle;
        end
    end

    task automatic abortRun(string why);
        $display("run aborted: %s", why);
        $display("errors %0d, results outstanding %0d", errCount, expQ.size());
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic stepReady();
        resultReady = randomReady ? lfsrBit() : 1'b1;
    endtask

    task automatic sendInst(issueT p);
        int   n;
        logic accepted;
        expQ.push_back(model(p));
        issue = p;
        issueValid = 1'b1;
        accepted = 1'b0;
        n = 0;
        while (!accepted && n < 100) begin
            @(posedge clk);
            accepted = issueReady;
            if (accepted) acceptCycle = cycle;
            @(negedge clk);
            stepReady();
            n++;
        end
        issueValid = 1'b0;
        if (!accepted) abortRun("the pipeline never accepted an issue");
    endtask

    task automatic sendOp(logic [6:0] f7, logic [2:0] f3, logic [6:0] op);
        sendInst(makePkt(encode(f7, f3, op)));
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (expQ.size() != 0 && n < 200) begin
            @(negedge clk);
            stepReady();
            n++;
        end
        if (expQ.size() != 0) abortRun("results still missing after the pipeline drained");
    endtask

    task automatic testArith();
        for (int rep = 0; rep < 3; rep++) begin
            for (int f = 0; f < 8; f++) begin
                sendOp(7'h00, 3'(f), 7'h33);
                sendOp(7'h00, 3'(f), 7'h13);
            end
            sendOp(7'h20, 3'h0, 7'h33); // sub
            sendOp(7'h20, 3'h5, 7'h33); // sra
            sendOp(7'h01, 3'h0, 7'h33); // mul
            sendOp(7'h20, 3'h5, 7'h13); // srai
        end
        drain();
    endtask

    task automatic testWord();
        for (int rep = 0; rep < 3; rep++) begin
            sendOp(7'h00, 3'h0, 7'h3b);
            sendOp(7'h20, 3'h0, 7'h3b);
            sendOp(7'h01, 3'h0, 7'h3b);
            sendOp(7'h00, 3'h1, 7'h3b);
            sendOp(7'h00, 3'h5, 7'h3b);
            sendOp(7'h20, 3'h5, 7'h3b);
            sendOp(7'h00, 3'h0, 7'h1b);
            sendOp(7'h00, 3'h1, 7'h1b);
            sendOp(7'h00, 3'h5, 7'h1b);
            sendOp(7'h20, 3'h5, 7'h1b);
        end
        drain();
    endtask

    task automatic testControl();
        issueT p;
        sendOp(7'h00, 3'h0, 7'h6f); // jal
        sendOp(7'h00, 3'h0, 7'h67); // jalr
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                for (int k = 0; k < 3; k++) begin
                    p = makePkt(encode(7'h00, 3'(f), 7'h63));
                    if (k == 0) p.rs2 = p.rs1;
                    else if (k == 1) p.rs2 = p.rs1 + 64'd1; // rs1 less
                    else p.rs2 = p.rs1 - 64'd1;
                    sendInst(p);
                end
            end
        end
        drain();
    endtask

    task automatic testMemory();
        for (int f = 0; f < 7; f++) sendOp(7'h00, 3'(f), 7'h03);
        for (int f = 0; f < 4; f++) sendOp(7'h00, 3'(f), 7'h23);
        drain();
    endtask

    task automatic testSystem();
        issueT p;
        sendOp(7'h00, 3'h0, 7'h37); // lui
        sendOp(7'h00, 3'h0, 7'h17); // auipc
        sendOp(7'h00, 3'h1, 7'h73); // csrrw
        sendOp(7'h00, 3'h2, 7'h73); // csrrs
        p = makePkt(encode(7'h00, 3'h0, 7'h73));
        p.imm = 64'h0;
        sendInst(p);
        p.imm = 64'h1;
        sendInst(p);
        p.imm = 64'h302;
        sendInst(p);
        sendOp(7'h01, 3'h4, 7'h33); // div
        sendOp(7'h01, 3'h4, 7'h3b); // divw
        drain();
    endtask

    task automatic testBackPressure();
        randomReady = 1'b1;
        for (int k = 0; k < 8; k++) sendOp(7'h00, 3'(lfsrBit() * 4 + lfsrBit() * 2 + 1), 7'h33);
        drain();
        randomReady = 1'b0;
        @(negedge clk);
        stepReady();
        sendOp(7'h00, 3'h0, 7'h33);
        drain();
        checkVal("latency", xlenT'(lastResultCycle - acceptCycle), xlenT'(4));
    endtask

    initial begin
        issue = '0;
        issueValid = 1'b0;
        resultReady = 1'b1;
        rstN = 1'b0;
        lfsrState = 32'h4fed;
        randomReady = 1'b0;
        errCount = 0;
        cycle = 0;
        acceptCycle = 0;
        lastResultCycle = 0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        testArith();
        testWord();
        testControl();
        testMemory();
        testSystem();
        testBackPressure();
        $display("errors %0d, results outstanding %0d", errCount, expQ.size());
        if (errCount == 0 && expQ.size() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/execPipe_checker.sv
`default_nettype none

module execPipe_checker import execPkg::*; (
    input wire logic   clk,
    input wire logic   rstN,
    input wire resultT result,
    input wire logic   resultValid,
    input wire logic   resultReady
);

    resultValidLowAfterReset: assert property (
        @(posedge clk) !rstN |=> !resultValid
    ) else $error("resultValid high in the cycle after reset");

    resultHeldUnderStall: assert property (
        @(posedge clk) disable iff (!rstN)
        resultValid && !resultReady |=> resultValid && $stable(result)
    ) else $error("result changed or vanished while stalled");

    illegalHasNoEffect: assert property (
        @(posedge clk) disable iff (!rstN)
        resultValid |-> !(result.illegal && (result.rdWrite || result.memWrite))
    ) else $error("illegal instruction still writes rd or memory");

endmodule

bind execPipe execPipe_checker execPipe_checker_inst (
    .clk         (clk),
    .rstN        (rstN),
    .result      (result),
    .resultValid (resultValid),
    .resultReady (resultReady)
);

`default_nettype wire

//--- filelist.f
+incdir+include
rtl/execPkg.sv
rtl/instDecoder.sv
rtl/operandStage.sv
rtl/aluStage.sv
rtl/writebackStage.sv
rtl/execPipe.sv
dv/execPipe_checker.sv
dv/execPipeTb.sv

//--- include/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

`define EXEC_XLEN   64
`define EXEC_INST_W 32

// trap causes, reported but not taken
`define CAUSE_ECALL  4'hb // environment call from M mode
`define CAUSE_EBREAK 4'h3 // breakpoint
`define CAUSE_MRET   4'hf

`endif

//--- rtl/aluStage.sv
`default_nettype none

module aluStage import execPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  operandT  inPkt,
    input  logic     inValid,
    output logic     inReady,
    output executedT outPkt,
    output logic     outValid,
    input  logic     outReady
);
    xlenT       opA;
    xlenT       opB;
    logic [5:0] shamt;
    xlenT       aluRes;

    assign opA = inPkt.opA;
    assign opB = inPkt.opB;

    // W forms shift by five bits only
    assign shamt = (inPkt.dec.ctrl.wbSel == wbAluW) ? {1'b0, opB[4:0]} : opB[5:0];

    always_comb begin
        case (inPkt.dec.ctrl.aluOp)
            aluAdd: aluRes = opA + opB;
            aluSub: aluRes = opA - opB;
            aluMul: aluRes = opA * opB; // low half of the product
            aluAnd: aluRes = opA & opB;
            aluOr: aluRes = opA | opB;
            aluXor: aluRes = opA ^ opB;
            aluSll: aluRes = opA << shamt;
            aluSrl: aluRes = opA >> shamt;
            aluSra: aluRes = $signed(opA) >>> shamt;
            aluSlt: aluRes = xlenT'($signed(opA) < $signed(opB));
            aluSltu: aluRes = xlenT'(opA < opB);
            aluPassA: aluRes = opA;
            aluPassB: aluRes = opB;
            default: aluRes = '0;
        endcase
    end

    assign inReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outPkt.op <= inPkt;
            outPkt.aluRes <= aluRes;
        end
    end

endmodule

`default_nettype wire

//--- rtl/execPipe.sv
`default_nettype none

module execPipe import execPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  issueT  issue,
    input  logic   issueValid,
    output logic   issueReady,
    output resultT result,
    output logic   resultValid,
    input  logic   resultReady
);
    decodedT  decPkt;
    logic     decValid;
    logic     decReady;
    operandT  opPkt;
    logic     opValid;
    logic     opReady;
    executedT exePkt;
    logic     exeValid;
    logic     exeReady;

    instDecoder instDecoder_inst (
        .clk      (clk),
        .rstN     (rstN),
        .inPkt    (issue),
        .inValid  (issueValid),
        .inReady  (issueReady),
        .outPkt   (decPkt),
        .outValid (decValid),
        .outReady (decReady)
    );

    operandStage operandStage_inst (
        .clk      (clk),
        .rstN     (rstN),
        .inPkt    (decPkt),
        .inValid  (decValid),
        .inReady  (decReady),
        .outPkt   (opPkt),
        .outValid (opValid),
        .outReady (opReady)
    );

    aluStage aluStage_inst (
        .clk      (clk),
        .rstN     (rstN),
        .inPkt    (opPkt),
        .inValid  (opValid),
        .inReady  (opReady),
        .outPkt   (exePkt),
        .outValid (exeValid),
        .outReady (exeReady)
    );

    writebackStage writebackStage_inst (
        .clk      (clk),
        .rstN     (rstN),
        .inPkt    (exePkt),
        .inValid  (exeValid),
        .inReady  (exeReady),
        .outPkt   (result),
        .outValid (resultValid),
        .outReady (resultReady)
    );

endmodule

`default_nettype wire

//--- rtl/execPkg.sv
`include "exec_settings.svh"
`default_nettype none

package execPkg;

    typedef logic [`EXEC_XLEN-1:0]   xlenT;
    typedef logic [`EXEC_INST_W-1:0] instT;
    typedef logic [7:0]              memMaskT;
    typedef logic [3:0]              causeT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluMul,
        aluAnd,
        aluOr,
        aluXor,
        aluSll,
        aluSrl,
        aluSra,
        aluSlt,
        aluSltu,
        aluPassA,
        aluPassB
    } aluOpT;

    typedef enum logic {
        opAPc,
        opARs1
    } opASelT;

    typedef enum logic [1:0] {
        opBImm,
        opBRs2,
        opBCsr
    } opBSelT;

    typedef enum logic [2:0] {
        wbAlu,
        wbLoad,
        wbPc4,
        wbAluW, // low word of alu result, sign extended
        wbCsr
    } wbSelT;

    typedef struct packed {
        instT inst;
        xlenT pc;
        xlenT rs1;
        xlenT rs2;
        xlenT imm;
        xlenT csrVal;
    } issueT;

    typedef struct packed {
        aluOpT      aluOp;
        opASelT     opASel;
        opBSelT     opBSel;
        wbSelT      wbSel;
        logic       rdWrite;
        logic       memRead;
        memMaskT    memMask;
        logic [3:0] readBytes;
        logic       loadSigned;
        logic       narrow32;
        logic       isBranch;
        logic       isJump;
        logic       jumpReg;
        logic       csrWrite;
        logic       illegal;
        logic       trap;
        causeT      cause;
    } ctrlT;

    typedef struct packed {
        issueT issue;
        ctrlT  ctrl;
    } decodedT;

    typedef struct packed {
        decodedT dec;
        xlenT    opA;
        xlenT    opB;
        xlenT    nextPc;
        logic    redirect;
    } operandT;

    typedef struct packed {
        operandT op;
        xlenT    aluRes;
    } executedT;

    typedef struct packed {
        logic       rdWrite;
        xlenT       rdData;
        logic       csrWrite;
        xlenT       csrData;
        logic       memRead;
        logic       memWrite;
        xlenT       memAddr;
        memMaskT    memMask;
        logic [3:0] readBytes;
        logic       loadSigned;
        xlenT       storeData;
        xlenT       nextPc;
        logic       redirect;
        logic       illegal;
        logic       trap;
        causeT      cause;
    } resultT;

endpackage

`default_nettype wire

//--- rtl/instDecoder.sv
`include "exec_settings.svh"
`default_nettype none

module instDecoder import execPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  issueT   inPkt,
    input  logic    inValid,
    output logic    inReady,
    output decodedT outPkt,
    output logic    outValid,
    input  logic    outReady
);
    logic [6:0] opCode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    ctrlT       ctrl;

    assign opCode = inPkt.inst[6:0];
    assign funct3 = inPkt.inst[14:12];
    assign funct7 = inPkt.inst[31:25];

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = aluAdd;
        ctrl.opASel = opARs1;
        ctrl.opBSel = opBImm;
        ctrl.wbSel = wbAlu;
        case (opCode)
            7'b0110011: begin // R type
                ctrl.opBSel = opBRs2;
                ctrl.rdWrite = 1'b1;
                case (funct7)
                    7'h00: begin
                        case (funct3)
                            3'h0: ctrl.aluOp = aluAdd;
                            3'h1: ctrl.aluOp = aluSll;
                            3'h2: ctrl.aluOp = aluSlt;
                            3'h3: ctrl.aluOp = aluSltu;
                            3'h4: ctrl.aluOp = aluXor;
                            3'h5: ctrl.aluOp = aluSrl;
                            3'h6: ctrl.aluOp = aluOr;
                            default: ctrl.aluOp = aluAnd;
                        endcase
                    end
                    7'h20: begin
                        if (funct3 == 3'h0) ctrl.aluOp = aluSub;
                        else if (funct3 == 3'h5) ctrl.aluOp = aluSra;
                        else ctrl.illegal = 1'b1;
                    end
                    7'h01: begin
                        if (funct3 == 3'h0) ctrl.aluOp = aluMul;
                        else ctrl.illegal = 1'b1; // mulh and div/rem not supported
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            7'b0010011: begin // I type alu
                ctrl.rdWrite = 1'b1;
                case (funct3)
                    3'h0: ctrl.aluOp = aluAdd;
                    3'h1: begin
                        ctrl.aluOp = aluSll;
                        ctrl.illegal = (funct7[6:1] != 6'h00);
                    end
                    3'h2: ctrl.aluOp = aluSlt;
                    3'h3: ctrl.aluOp = aluSltu;
                    3'h4: ctrl.aluOp = aluXor;
                    3'h5: begin
                        if (funct7[6:1] == 6'h00) ctrl.aluOp = aluSrl;
                        else if (funct7[6:1] == 6'h10) ctrl.aluOp = aluSra;
                        else ctrl.illegal = 1'b1;
                    end
                    3'h6: ctrl.aluOp = aluOr;
                    default: ctrl.aluOp = aluAnd;
                endcase
            end
            7'b0111011: begin // R type, W forms
                ctrl.opBSel = opBRs2;
                ctrl.rdWrite = 1'b1;
                ctrl.wbSel = wbAluW;
                case ({funct7, funct3})
                    {7'h00, 3'h0}: ctrl.aluOp = aluAdd;
                    {7'h20, 3'h0}: ctrl.aluOp = aluSub;
                    {7'h01, 3'h0}: ctrl.aluOp = aluMul;
                    {7'h00, 3'h1}: ctrl.aluOp = aluSll;
                    {7'h00, 3'h5}: begin
                        ctrl.aluOp = aluSrl;
                        ctrl.narrow32 = 1'b1;
                    end
                    {7'h20, 3'h5}: begin
                        ctrl.aluOp = aluSra;
                        ctrl.narrow32 = 1'b1;
                    end
                    default: ctrl.illegal = 1'b1; // divw, remw and friends land here
                endcase
            end
            7'b0011011: begin // I type, W forms
                ctrl.rdWrite = 1'b1;
                ctrl.wbSel = wbAluW;
                case ({funct7, funct3})
                    {7'h00, 3'h1}: ctrl.aluOp = aluSll;
                    {7'h00, 3'h5}: begin
                        ctrl.aluOp = aluSrl;
                        ctrl.narrow32 = 1'b1;
                    end
                    {7'h20, 3'h5}: begin
                        ctrl.aluOp = aluSra;
                        ctrl.narrow32 = 1'b1;
                    end
                    default: begin
                        ctrl.aluOp = aluAdd; // addiw
                        ctrl.illegal = (funct3 != 3'h0);
                    end
                endcase
            end
            7'b0110111: begin // lui
                ctrl.rdWrite = 1'b1;
                ctrl.aluOp = aluPassB;
            end
            7'b0010111: begin // auipc
                ctrl.rdWrite = 1'b1;
                ctrl.opASel = opAPc;
            end
            7'b1101111: begin // jal
                ctrl.rdWrite = 1'b1;
                ctrl.isJump = 1'b1;
                ctrl.wbSel = wbPc4;
            end
            7'b1100111: begin // jalr
                ctrl.rdWrite = 1'b1;
                ctrl.isJump = 1'b1;
                ctrl.jumpReg = 1'b1;
                ctrl.wbSel = wbPc4;
                ctrl.illegal = (funct3 != 3'h0);
            end
            7'b1100011: begin // branches
                ctrl.isBranch = 1'b1;
                ctrl.opBSel = opBRs2;
                ctrl.aluOp = aluSub;
                ctrl.illegal = (funct3 == 3'h2) || (funct3 == 3'h3);
            end
            7'b0000011: begin // loads, address is rs1 + imm
                ctrl.rdWrite = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.wbSel = wbLoad;
                ctrl.loadSigned = !funct3[2];
                ctrl.readBytes = 4'h1 << funct3[1:0];
                ctrl.illegal = (funct3 == 3'h7);
            end
            7'b0100011: begin // stores
                case (funct3)
                    3'h0: ctrl.memMask = 8'h01;
                    3'h1: ctrl.memMask = 8'h03;
                    3'h2: ctrl.memMask = 8'h0f;
                    3'h3: ctrl.memMask = 8'hff;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            7'b1110011: begin // system
                case (funct3)
                    3'h1: begin // csrrw, old csr to rd, rs1 to csr
                        ctrl.rdWrite = 1'b1;
                        ctrl.csrWrite = 1'b1;
                        ctrl.wbSel = wbCsr;
                        ctrl.aluOp = aluPassA;
                    end
                    3'h2: begin // csrrs
                        ctrl.rdWrite = 1'b1;
                        ctrl.csrWrite = 1'b1;
                        ctrl.wbSel = wbCsr;
                        ctrl.opBSel = opBCsr;
                        ctrl.aluOp = aluOr;
                    end
                    3'h0: begin
                        ctrl.trap = 1'b1;
                        case (inPkt.imm)
                            64'h0: ctrl.cause = `CAUSE_ECALL;
                            64'h1: ctrl.cause = `CAUSE_EBREAK;
                            64'h302: ctrl.cause = `CAUSE_MRET;
                            default: ctrl.illegal = 1'b1;
                        endcase
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            default: ctrl.illegal = 1'b1;
        endcase

        // nothing architectural may happen for a bad encoding
        if (ctrl.illegal) begin
            ctrl.rdWrite = 1'b0;
            ctrl.memRead = 1'b0;
            ctrl.memMask = '0;
            ctrl.csrWrite = 1'b0;
            ctrl.isJump = 1'b0;
            ctrl.isBranch = 1'b0;
            ctrl.trap = 1'b0;
            ctrl.cause = '0;
        end
    end

    assign inReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outPkt.issue <= inPkt;
            outPkt.ctrl <= ctrl;
        end
    end

endmodule

`default_nettype wire

//--- rtl/operandStage.sv
`default_nettype none

module operandStage import execPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  decodedT inPkt,
    input  logic    inValid,
    output logic    inReady,
    output operandT outPkt,
    output logic    outValid,
    input  logic    outReady
);
    xlenT opA;
    xlenT opB;
    xlenT nextPc;
    logic taken;

    always_comb begin
        opA = (inPkt.ctrl.opASel == opAPc) ? inPkt.issue.pc : inPkt.issue.rs1;
        // sraw needs the word sign in the upper half, srlw needs zeros
        if (inPkt.ctrl.narrow32) begin
            if (inPkt.ctrl.aluOp == aluSra) opA = {{32{opA[31]}}, opA[31:0]};
            else opA = {32'h0, opA[31:0]};
        end
        case (inPkt.ctrl.opBSel)
            opBRs2: opB = inPkt.issue.rs2;
            opBCsr: opB = inPkt.issue.csrVal;
            default: opB = inPkt.issue.imm;
        endcase
    end

    always_comb begin
        case (inPkt.issue.inst[14:12])
            3'h0: taken = (inPkt.issue.rs1 == inPkt.issue.rs2); // beq
            3'h1: taken = (inPkt.issue.rs1 != inPkt.issue.rs2); // bne
            3'h4: taken = ($signed(inPkt.issue.rs1) < $signed(inPkt.issue.rs2));
            3'h5: taken = ($signed(inPkt.issue.rs1) >= $signed(inPkt.issue.rs2));
            3'h6: taken = (inPkt.issue.rs1 < inPkt.issue.rs2); // bltu
            3'h7: taken = (inPkt.issue.rs1 >= inPkt.issue.rs2); // bgeu
            default: taken = 1'b0;
        endcase
        taken = taken && inPkt.ctrl.isBranch;

        if (inPkt.ctrl.isJump && inPkt.ctrl.jumpReg) begin
            nextPc = (inPkt.issue.rs1 + inPkt.issue.imm) & ~xlenT'(1);
        end else if (inPkt.ctrl.isJump || taken) begin
            nextPc = inPkt.issue.pc + inPkt.issue.imm;
        end else begin
            nextPc = inPkt.issue.pc + xlenT'(4);
        end
    end

    assign inReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outPkt.dec <= inPkt;
            outPkt.opA <= opA;
            outPkt.opB <= opB;
            outPkt.nextPc <= nextPc;
            outPkt.redirect <= inPkt.ctrl.isJump || taken;
        end
    end

endmodule

`default_nettype wire

//--- rtl/writebackStage.sv
`default_nettype none

module writebackStage import execPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  executedT inPkt,
    input  logic     inValid,
    output logic     inReady,
    output resultT   outPkt,
    output logic     outValid,
    input  logic     outReady
);
    ctrlT   ctrl;
    issueT  issue;
    resultT res;

    assign ctrl = inPkt.op.dec.ctrl;
    assign issue = inPkt.op.dec.issue;

    always_comb begin
        case (ctrl.wbSel)
            wbAluW: res.rdData = {{32{inPkt.aluRes[31]}}, inPkt.aluRes[31:0]};
            wbPc4: res.rdData = issue.pc + xlenT'(4);
            wbCsr: res.rdData = issue.csrVal;
            wbLoad: res.rdData = '0; // load data is merged downstream
            default: res.rdData = inPkt.aluRes;
        endcase
        res.rdWrite = ctrl.rdWrite;
        res.csrWrite = ctrl.csrWrite;
        res.csrData = inPkt.aluRes;
        res.memRead = ctrl.memRead;
        res.memWrite = |ctrl.memMask;
        res.memAddr = inPkt.aluRes;
        res.memMask = ctrl.memMask;
        res.readBytes = ctrl.readBytes;
        res.loadSigned = ctrl.loadSigned;
        res.storeData = res.memWrite ? issue.rs2 : '0;
        res.nextPc = inPkt.op.nextPc;
        res.redirect = inPkt.op.redirect;
        res.illegal = ctrl.illegal;
        res.trap = ctrl.trap;
        res.cause = ctrl.cause;
    end

    assign inReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outPkt <= res;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the execPipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module execPipeTb -f filelist.f -o simExecPipe
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simExecPipe > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
    exit 1
fi

exit 0
